//--- hdl/dds_channel.sv
`timescale 1ns/100ps
`include "dds_config.svh"

module dds_channel (
    input  logic                clk,
    input  logic                nreset,
    input  dds_pkg::ch_req_t    req,
    input  logic                req_valid,
    output logic                out,
    output dds_pkg::ch_status_t status
);

    logic [`DDS_CODE_BITS-1:0] code_bak; // kept while disabled
    logic [`DDS_CODE_BITS-1:0] active_code;
    logic [`DDS_CODE_BITS-1:0] phase;
    logic                      enabled;

    always_ff @(posedge clk) begin
        if (!nreset) begin
            code_bak <= '0;
            enabled  <= 1'b0;
        end else if (req_valid) begin
            if (req.set_code) begin
                code_bak <= req.code;
            end
            if (req.set_enable) begin
                enabled <= req.enable;
            end
        end
    end

    assign active_code = enabled ? code_bak : '0;

    always_ff @(posedge clk) begin
        if (!nreset || !enabled) begin
            phase <= '0;
        end else begin
            phase <= phase + active_code;
        end
    end

    // phase clears a cycle late, so mask with enabled
    assign out = enabled & phase[`DDS_CODE_BITS-1];

    assign status.enabled = enabled;
    assign status.code    = active_code;

endmodule

//--- hdl/dds_cmd_decoder.sv
`timescale 1ns/100ps
`include "dds_config.svh"

module dds_cmd_decoder (
    input  logic                    clk,
    input  logic                    nreset,
    input  dds_pkg::spi_frame_t     frame,
    input  logic                    frame_valid,
    output dds_pkg::query_op_e      query,
    output logic                    query_valid,
    output dds_pkg::ch_req_t        req [`DDS_NUM_CH],
    output logic [`DDS_NUM_CH-1:0]  req_valid
);

    localparam int EN_TOP = `DDS_ENABLE_BITS - 1;
    localparam int SF_TOP = `DDS_SETFREQ_BITS - 1;

    dds_pkg::query_op_e     query_next;
    dds_pkg::ch_req_t       req_next;
    logic [`DDS_NUM_CH-1:0] hit;
    logic [1:0]             ch_sel;

    always_comb begin
        query_next = dds_pkg::QUERY_NONE;
        req_next   = '0;
        hit        = '0;
        ch_sel     = 2'd0;
        case (frame.nbits)
            8'(`DDS_QUERY_BITS): begin
                case (frame.bits[7:0])
                    8'd0:    query_next = dds_pkg::QUERY_ID;
                    8'd1:    query_next = dds_pkg::QUERY_CONFIG;
                    8'd2:    query_next = dds_pkg::QUERY_STATUS;
                    default: query_next = dds_pkg::QUERY_NONE;
                endcase
            end
            8'(`DDS_ENABLE_BITS): begin
                if (frame.bits[EN_TOP -: 8] == dds_pkg::CLASS_DDS &&
                    frame.bits[EN_TOP-8 -: 8] == dds_pkg::DDS_ENABLE) begin
                    ch_sel              = frame.bits[9:8];
                    req_next.set_enable = 1'b1;
                    req_next.enable     = |frame.bits[7:0];
                    hit[ch_sel]         = 1'b1;
                end
            end
            8'(`DDS_SETFREQ_BITS): begin
                if (frame.bits[SF_TOP -: 8] == dds_pkg::CLASS_DDS &&
                    frame.bits[SF_TOP-8 -: 8] == dds_pkg::DDS_SET_FREQ) begin
                    ch_sel            = frame.bits[SF_TOP-22 -: 2];
                    req_next.set_code = 1'b1;
                    // little endian tuning word
                    req_next.code     = {frame.bits[31:24], frame.bits[39:32],
                                         frame.bits[47:40], frame.bits[55:48]};
                    hit[ch_sel]       = 1'b1;
                end
            end
            default: ;
        endcase
    end

    // every frame gets a reply, dds commands get the zero one
    always_ff @(posedge clk) begin
        if (!nreset) begin
            query       <= dds_pkg::QUERY_NONE;
            query_valid <= 1'b0;
            req_valid   <= '0;
        end else begin
            query_valid <= frame_valid;
            req_valid   <= frame_valid ? hit : '0;
            if (frame_valid) begin
                query <= query_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `DDS_NUM_CH; i++) begin
            if (frame_valid && hit[i]) begin
                req[i] <= req_next;
            end
        end
    end

endmodule

//--- hdl/dds_config.svh
`ifndef DDS_CONFIG_SVH
`define DDS_CONFIG_SVH

// frame lengths in bits
`define DDS_FRAME_BITS 120
`define DDS_QUERY_BITS 8
`define DDS_ENABLE_BITS 32
`define DDS_SETFREQ_BITS 104

`define DDS_NUM_CH 4

// identity and capabilities reported by the config query
`define DDS_ID 8'h01
`define DDS_TYPE 16'd6
`define DDS_METER_TYPE 16'd0
`define DDS_MCLK 64'd270000000
`define DDS_MAX_MV 16'd3300
`define DDS_MAX_ATT 8'd0

// width of a tuning word and of the phase accumulator
`define DDS_CODE_BITS 32

`endif

//--- hdl/dds_pkg.sv
`include "dds_config.svh"

package dds_pkg;

    // query opcodes, sent as an 8 bit frame
    typedef enum logic [7:0] {
        QUERY_ID     = 8'd0,
        QUERY_CONFIG = 8'd1,
        QUERY_STATUS = 8'd2,
        QUERY_NONE   = 8'hff // zero reply
    } query_op_e;

    // subcodes of the dds command class
    typedef enum logic [7:0] {
        DDS_SET_FREQ = 8'd2,
        DDS_ENABLE   = 8'd5
    } dds_cmd_e;

    typedef enum logic [7:0] {
        CLASS_DDS = 8'd3
    } cmd_class_e;

    // one finished spi transaction
    typedef struct packed {
        logic [`DDS_FRAME_BITS-1:0] bits;
        logic [7:0]                 nbits;
    } spi_frame_t;

    typedef struct packed {
        logic                       set_code;
        logic                       set_enable;
        logic                       enable;
        logic [`DDS_CODE_BITS-1:0]  code;
    } ch_req_t;

    typedef struct packed {
        logic                       enabled;
        logic [`DDS_CODE_BITS-1:0]  code; // active code, 0 when disabled
    } ch_status_t;

endpackage

//--- hdl/dds_response.sv
`timescale 1ns/100ps
`include "dds_config.svh"

module dds_response (
    input  logic                       clk,
    input  logic                       nreset,
    input  dds_pkg::query_op_e         query,
    input  logic                       query_valid,
    input  dds_pkg::ch_status_t        status [`DDS_NUM_CH],
    output logic [`DDS_FRAME_BITS-1:0] reply,
    output logic                       reply_load
);

    localparam int STATUS_BITS = 8 + `DDS_NUM_CH * `DDS_CODE_BITS;

    localparam logic [15:0] TYPE_W  = `DDS_TYPE;
    localparam logic [15:0] METER_W = `DDS_METER_TYPE;
    localparam logic [63:0] MCLK_W  = `DDS_MCLK;
    localparam logic [15:0] MV_W    = `DDS_MAX_MV;

    localparam logic [`DDS_FRAME_BITS-1:0] CONFIG_REPLY = {
        TYPE_W[7:0], TYPE_W[15:8],
        METER_W[7:0], METER_W[15:8],
        MCLK_W[7:0], MCLK_W[15:8], MCLK_W[23:16], MCLK_W[31:24],
        MCLK_W[39:32], MCLK_W[47:40], MCLK_W[55:48], MCLK_W[63:56],
        MV_W[7:0], MV_W[15:8],
        8'(`DDS_MAX_ATT)
    };

    function automatic logic [31:0] le32(input logic [31:0] v);
        return {v[7:0], v[15:8], v[23:16], v[31:24]};
    endfunction

    logic [STATUS_BITS-1:0]     status_bits;
    logic [`DDS_FRAME_BITS-1:0] reply_next;

    always_comb begin
        status_bits = '0;
        for (int i = 0; i < `DDS_NUM_CH; i++) begin
            status_bits[STATUS_BITS-8+i] = status[i].enabled;
            status_bits[STATUS_BITS-9-32*i -: 32] = le32(status[i].code);
        end
    end

    always_comb begin
        case (query)
            dds_pkg::QUERY_ID:     reply_next = {`DDS_ID, {(`DDS_FRAME_BITS-8){1'b0}}};
            dds_pkg::QUERY_CONFIG: reply_next = CONFIG_REPLY;
            // upper half of the last code falls off the frame
            dds_pkg::QUERY_STATUS: reply_next = status_bits[STATUS_BITS-1 -: `DDS_FRAME_BITS];
            default:               reply_next = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (query_valid) begin
            reply <= reply_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!nreset) begin
            reply_load <= 1'b0;
        end else begin
            reply_load <= query_valid;
        end
    end

endmodule

//--- hdl/dds_top.sv
`timescale 1ns/100ps
`include "dds_config.svh"

module dds_top (
    input  logic                   clk,
    input  logic                   nreset,
    input  logic                   sck,
    input  logic                   mosi,
    input  logic                   ncs,
    output logic                   miso,
    output logic [`DDS_NUM_CH-1:0] out
);

    dds_pkg::spi_frame_t        frame;
    logic                       frame_valid;
    dds_pkg::query_op_e         query;
    logic                       query_valid;
    dds_pkg::ch_req_t           req [`DDS_NUM_CH];
    logic [`DDS_NUM_CH-1:0]     req_valid;
    dds_pkg::ch_status_t        status [`DDS_NUM_CH];
    logic [`DDS_FRAME_BITS-1:0] reply;
    logic                       reply_load;

    spi_frame_rx u_rx (
        .clk         (clk),
        .nreset      (nreset),
        .sck         (sck),
        .mosi        (mosi),
        .ncs         (ncs),
        .reply       (reply),
        .reply_load  (reply_load),
        .miso        (miso),
        .frame       (frame),
        .frame_valid (frame_valid)
    );

    dds_cmd_decoder u_dec (
        .clk         (clk),
        .nreset      (nreset),
        .frame       (frame),
        .frame_valid (frame_valid),
        .query       (query),
        .query_valid (query_valid),
        .req         (req),
        .req_valid   (req_valid)
    );

    for (genvar i = 0; i < `DDS_NUM_CH; i++) begin : g_ch
        dds_channel u_ch (
            .clk       (clk),
            .nreset    (nreset),
            .req       (req[i]),
            .req_valid (req_valid[i]),
            .out       (out[i]),
            .status    (status[i])
        );
    end

    dds_response u_resp (
        .clk         (clk),
        .nreset      (nreset),
        .query       (query),
        .query_valid (query_valid),
        .status      (status),
        .reply       (reply),
        .reply_load  (reply_load)
    );

endmodule

//--- hdl/spi_frame_rx.sv
`timescale 1ns/100ps
`include "dds_config.svh"

module spi_frame_rx (
    input  logic                       clk,
    input  logic                       nreset,
    input  logic                       sck,
    input  logic                       mosi,
    input  logic                       ncs,
    input  logic [`DDS_FRAME_BITS-1:0] reply,
    input  logic                       reply_load,
    output logic                       miso,
    output dds_pkg::spi_frame_t        frame,
    output logic                       frame_valid
);

    logic [2:0]                 pin_meta; // {ncs, mosi, sck}
    logic [2:0]                 pin_sync;
    logic                       sck_s;
    logic                       mosi_s;
    logic                       ncs_s;
    logic                       sck_q;
    logic                       ncs_q;
    logic                       sck_rise;
    logic                       sck_fall;
    logic                       ncs_rise;
    logic [7:0]                 bit_cnt;
    logic [`DDS_FRAME_BITS-1:0] cmd_sr;
    logic [`DDS_FRAME_BITS-1:0] resp_sr;

    always_ff @(posedge clk) begin
        if (!nreset) begin
            pin_meta <= 3'b100; // ncs idles high
            pin_sync <= 3'b100;
            sck_q    <= 1'b0;
            ncs_q    <= 1'b1;
        end else begin
            pin_meta <= {ncs, mosi, sck};
            pin_sync <= pin_meta;
            sck_q    <= sck_s;
            ncs_q    <= ncs_s;
        end
    end

    assign sck_s  = pin_sync[0];
    assign mosi_s = pin_sync[1];
    assign ncs_s  = pin_sync[2];

    assign sck_rise = sck_s & ~sck_q & ~ncs_s;
    assign sck_fall = ~sck_s & sck_q & ~ncs_s;
    assign ncs_rise = ncs_s & ~ncs_q;

    always_ff @(posedge clk) begin
        if (!nreset) begin
            bit_cnt <= '0;
        end else if (ncs_rise) begin
            bit_cnt <= '0;
        end else if (sck_rise) begin
            bit_cnt <= bit_cnt + 8'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (sck_rise) begin
            cmd_sr <= {cmd_sr[`DDS_FRAME_BITS-2:0], mosi_s}; // msb first
        end
    end

    always_ff @(posedge clk) begin
        if (!nreset) begin
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= ncs_rise;
        end
    end

    always_ff @(posedge clk) begin
        if (ncs_rise) begin
            frame.bits  <= cmd_sr;
            frame.nbits <= bit_cnt;
        end
    end

    // reply goes out on falling sck so the master samples it on the rising edge
    always_ff @(posedge clk) begin
        if (!nreset) begin
            resp_sr <= '0;
        end else if (reply_load) begin
            resp_sr <= reply;
        end else if (sck_fall) begin
            resp_sr <= {resp_sr[`DDS_FRAME_BITS-2:0], 1'b0};
        end
    end

    assign miso = ncs ? 1'b0 : resp_sr[`DDS_FRAME_BITS-1];

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and check the log
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/100ps \
    --top-module dds_tb \
    -f verilog.f

./obj_dir/Vdds_tb | tee sim.log

if grep -qx "PASS: all tests" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

//--- verification/dds_checker.sv
`timescale 1ns/100ps
`include "dds_config.svh"

module dds_checker (
    input logic                   clk,
    input logic                   nreset,
    input logic                   frame_valid,
    input logic                   query_valid,
    input logic [`DDS_NUM_CH-1:0] req_valid,
    input logic                   reply_load,
    input dds_pkg::ch_status_t    status [`DDS_NUM_CH],
    input logic [`DDS_NUM_CH-1:0] out
);

    // all pulses and tone outputs low right after a reset cycle
    a_reset_quiet: assert property (@(posedge clk)
        !nreset |=> !frame_valid && !query_valid && req_valid == '0 && !reply_load && out == '0)
        else $error("outputs not quiet after reset");

    a_frame_pulse: assert property (@(posedge clk) disable iff (!nreset)
        frame_valid |=> !frame_valid)
        else $error("frame_valid held for two cycles");

    for (genvar i = 0; i < `DDS_NUM_CH; i++) begin : g_ch
        a_disabled_low: assert property (@(posedge clk) disable iff (!nreset)
            !status[i].enabled |-> !out[i])
            else $error("disabled channel drives its output high");
    end

endmodule

bind dds_top dds_checker u_checker (
    .clk         (clk),
    .nreset      (nreset),
    .frame_valid (frame_valid),
    .query_valid (query_valid),
    .req_valid   (req_valid),
    .reply_load  (reply_load),
    .status      (status),
    .out         (out)
);

//--- verification/dds_tb.sv
`timescale 1ns/100ps
`include "dds_config.svh"

module dds_tb;

    localparam int FB = `DDS_FRAME_BITS;
    // about 65k cycles of traffic, so the limit leaves a wide margin
    localparam int MAX_CYCLES = 200000;
    localparam logic [31:0] TONE_CODE = 32'h1000_0000; // 2^28, 16 cycle period

    logic                   clk;
    logic                   nreset;
    logic                   sck;
    logic                   mosi;
    logic                   ncs;
    logic                   miso;
    logic [`DDS_NUM_CH-1:0] out;

    logic                   model_en [`DDS_NUM_CH];
    logic [31:0]            model_code [`DDS_NUM_CH];
    logic [FB-1:0]          pending = '0; // reply due in the next transaction
    logic [FB-1:0]          exp_q [$];
    logic [FB-1:0]          got_q [$];
    logic [FB-1:0]          tol_q [$];
    string                  name_q [$];
    int                     errors = 0;
    int                     checks = 0;
    int                     cycles;

    dds_top UUT (
        .clk    (clk),
        .nreset (nreset),
        .sck    (sck),
        .mosi   (mosi),
        .ncs    (ncs),
        .miso   (miso),
        .out    (out)
    );

    always #5 clk = ~clk;

    // expected reply of a frame, also applies the frame to the channel model
    function automatic logic [FB-1:0] ref_reply(input int nbits, input logic [FB-1:0] bits);
        logic [7:0]    b [15];
        logic [7:0]    r [17];
        logic [FB-1:0] res;
        int            ch;
        for (int k = 0; k < 15; k++) begin
            b[k] = (8 * k + 8 <= nbits) ? 8'(bits >> (nbits - 8 - 8 * k)) : 8'h00;
        end
        for (int k = 0; k < 17; k++) begin
            r[k] = 8'h00;
        end
        ch = int'(b[2][1:0]);
        if (nbits == `DDS_QUERY_BITS && b[0] == 8'd0) begin
            r[0] = `DDS_ID;
        end else if (nbits == `DDS_QUERY_BITS && b[0] == 8'd1) begin
            for (int k = 0; k < 2; k++) begin
                r[k]      = 8'(`DDS_TYPE >> (8 * k));
                r[2 + k]  = 8'(`DDS_METER_TYPE >> (8 * k));
                r[12 + k] = 8'(`DDS_MAX_MV >> (8 * k));
            end
            for (int k = 0; k < 8; k++) begin
                r[4 + k] = 8'(`DDS_MCLK >> (8 * k));
            end
            r[14] = `DDS_MAX_ATT;
        end else if (nbits == `DDS_QUERY_BITS && b[0] == 8'd2) begin
            for (int c = 0; c < `DDS_NUM_CH; c++) begin
                r[0][c] = model_en[c];
                for (int k = 0; k < 4; k++) begin
                    r[1 + 4 * c + k] = model_en[c] ? 8'(model_code[c] >> (8 * k)) : 8'h00;
                end
            end
        end else if (nbits == `DDS_ENABLE_BITS && b[0] == 8'd3 && b[1] == 8'd5) begin
            model_en[ch] = (b[3] != 8'd0);
        end else if (nbits == `DDS_SETFREQ_BITS && b[0] == 8'd3 && b[1] == 8'd2) begin
            model_code[ch] = {b[9], b[8], b[7], b[6]}; // little endian word
        end
        res = '0;
        for (int k = 0; k < 15; k++) begin
            res[FB - 1 - 8 * k -: 8] = r[k]; // last two status bytes fall off
        end
        return res;
    endfunction

    function automatic logic [FB-1:0] freq_frame(input logic [7:0] cls, input int ch,
                                                 input logic [31:0] code);
        logic [103:0] f;
        f = {cls, 8'd2, 8'(ch), 24'd0, code[7:0], code[15:8], code[23:16], code[31:24],
             24'd0};
        return FB'(f);
    endfunction

    function automatic logic [FB-1:0] enable_frame(input int ch, input logic [7:0] en);
        return FB'({8'd3, 8'd5, 8'(ch), en});
    endfunction

    task automatic queue_check(input string what, input logic [FB-1:0] exp,
                               input logic [FB-1:0] got, input logic [FB-1:0] tol);
        exp_q.push_back(exp);
        got_q.push_back(got);
        tol_q.push_back(tol);
        name_q.push_back(what);
    endtask

    // one spi transaction, msb first, miso sampled just before each rising sck
    task automatic spi_xfer(input logic [FB-1:0] bits, input int nbits, input string what);
        logic [FB-1:0] rx;
        rx = '0;
        @(posedge clk);
        #1 ncs = 1'b0;
        for (int i = nbits - 1; i >= 0; i--) begin
            mosi = bits[i];
            repeat (8) @(posedge clk);
            #1 rx = {rx[FB-2:0], miso};
            sck = 1'b1;
            repeat (8) @(posedge clk);
            #1 sck = 1'b0;
        end
        repeat (8) @(posedge clk);
        #1 ncs = 1'b1;
        mosi = 1'b0;
        queue_check({"miso ", what}, pending >> (FB - nbits), rx, '0);
        pending = ref_reply(nbits, bits);
        repeat (16) @(posedge clk); // command applied and reply loaded by now
    endtask

    task automatic read_status(input string what);
        spi_xfer(FB'(8'd2), `DDS_QUERY_BITS, "get status");
        spi_xfer('0, FB, what);
    endtask

    task automatic count_edges(input int ch, input int ncyc, output int rises);
        logic prev;
        prev  = out[ch];
        rises = 0;
        repeat (ncyc) begin
            @(posedge clk);
            #1;
            if (out[ch] && !prev)
                rises++;
            prev = out[ch];
        end
    endtask

    always @(posedge clk) begin
        logic [FB-1:0] e;
        logic [FB-1:0] g;
        logic [FB-1:0] t;
        string         n;
        while (got_q.size() > 0) begin
            e = exp_q.pop_front();
            g = got_q.pop_front();
            t = tol_q.pop_front();
            n = name_q.pop_front();
            checks++;
            assert (g + t >= e && g <= e + t) else begin
                errors++;
                $display("[ERROR] %s expected %h got %h", n, e, g);
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        int ch;
        int rises;
        logic [FB-1:0] frm;
        void'($urandom(47));
        clk    = 1'b0;
        nreset = 1'b0;
        sck    = 1'b0;
        mosi   = 1'b0;
        ncs    = 1'b1;
        for (int c = 0; c < `DDS_NUM_CH; c++) begin
            model_en[c]   = 1'b0;
            model_code[c] = '0;
        end
        repeat (2) @(posedge clk);
        #1 nreset = 1'b1;

        spi_xfer(FB'(8'd0), `DDS_QUERY_BITS, "get id");
        spi_xfer('0, FB, "id reply");
        spi_xfer(FB'(8'd1), `DDS_QUERY_BITS, "get config");
        spi_xfer('0, FB, "config reply");

        // tuning word goes to the backup while the channel is off
        ch = int'($urandom_range(3, 0));
        spi_xfer(freq_frame(8'd3, ch, TONE_CODE), `DDS_SETFREQ_BITS, "set freq");
        count_edges(ch, 256, rises);
        queue_check($sformatf("out[%0d] edges while disabled", ch), '0, FB'(rises), '0);
        read_status("status after set freq");
        spi_xfer(enable_frame(ch, 8'd1), `DDS_ENABLE_BITS, "enable");
        count_edges(ch, 1024, rises);
        queue_check($sformatf("out[%0d] rising edges", ch),
                    FB'((64'd1024 * 64'(TONE_CODE)) >> 32), FB'(rises), FB'(1));
        read_status("status after enable");

        spi_xfer(enable_frame(ch, 8'd0), `DDS_ENABLE_BITS, "disable");
        queue_check($sformatf("out[%0d] after disable", ch), '0, FB'(out[ch]), '0);
        count_edges(ch, 256, rises);
        queue_check($sformatf("out[%0d] edges after disable", ch), '0, FB'(rises), '0);
        read_status("status after disable");

        // channel on again so a stray tuning word shows up in status
        spi_xfer(enable_frame(ch, 8'd1), `DDS_ENABLE_BITS, "enable again");
        frm = freq_frame(8'd4, ch, 32'hdead_beef); // wrong class
        spi_xfer(frm, `DDS_SETFREQ_BITS, "wrong class");
        spi_xfer(FB'({8'd3, 8'd5, 8'((ch + 1) % `DDS_NUM_CH), 8'd1, 8'd0}), 40, "odd length");
        read_status("status after rejected frames");

        for (int n = 0; n < 12; n++) begin
            ch = n % `DDS_NUM_CH;
            if ($urandom_range(1, 0) == 1) begin
                spi_xfer(freq_frame(8'd3, ch, $urandom()), `DDS_SETFREQ_BITS, "random freq");
            end else begin
                spi_xfer(enable_frame(ch, 8'($urandom_range(2, 0))), `DDS_ENABLE_BITS,
                         "random enable");
            end
            read_status("status after random command");
        end

        while (got_q.size() > 0) begin
            @(posedge clk);
        end
        $display("tests done, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+hdl
hdl/dds_pkg.sv
hdl/spi_frame_rx.sv
hdl/dds_cmd_decoder.sv
hdl/dds_channel.sv
hdl/dds_response.sv
hdl/dds_top.sv
verification/dds_checker.sv
verification/dds_tb.sv
